// File: source/ttt_config.svh
`ifndef TTT_CONFIG_SVH
`define TTT_CONFIG_SVH

// Board geometry.
`define TTT_CELLS 9

// Position code for no winning line.
`define TTT_NO_POS 15

// AXI4-Lite bus widths.
`define TTT_ADDR_W 5
`define TTT_DATA_W 32

`endif

// File: source/ttt_game_pkg.sv
package ttt_game_pkg;

	// Cell contents, also used for player and winner codes.
	typedef enum logic [1:0]
	{
		cell_empty  = 2'd0,
		cell_cross  = 2'd1,
		cell_nought = 2'd2,
		cell_none   = 2'd3
	} cell_t;

	// Cell index 0..8, top left to bottom right.
	typedef logic [3:0] pos_t;

endpackage

// File: source/ttt_regs_pkg.sv
`include "ttt_config.svh"

package ttt_regs_pkg;

	// Register offsets.
	localparam logic [`TTT_ADDR_W-1:0] reg_move    = `TTT_ADDR_W'(8'h00);
	localparam logic [`TTT_ADDR_W-1:0] reg_control = `TTT_ADDR_W'(8'h04);
	localparam logic [`TTT_ADDR_W-1:0] reg_status  = `TTT_ADDR_W'(8'h08);
	localparam logic [`TTT_ADDR_W-1:0] reg_board   = `TTT_ADDR_W'(8'h0C);
	localparam logic [`TTT_ADDR_W-1:0] reg_line    = `TTT_ADDR_W'(8'h10);

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Status register fields.
	localparam int st_winner = 0;
	localparam int st_win    = 2;
	localparam int st_full   = 3;
	localparam int st_turn   = 4;
	localparam int st_over   = 6;

	localparam int ctl_new_game = 0;

endpackage

// File: source/game_state_memory.sv
`timescale 1ns/1ps
`include "ttt_config.svh"

module game_state_memory (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic we,
	input ttt_game_pkg::pos_t wr_addr,
	input ttt_game_pkg::cell_t data_in,
	output logic [2*`TTT_CELLS-1:0] board,
	output ttt_game_pkg::cell_t winner,
	output ttt_game_pkg::pos_t pos1,
	output ttt_game_pkg::pos_t pos2,
	output ttt_game_pkg::pos_t pos3,
	output logic win,
	output logic full
);

	import ttt_game_pkg::*;

	// Rows, then columns, then main diagonal, then anti-diagonal.
	localparam pos_t line_tab [8][3] = '{
		'{4'd0, 4'd1, 4'd2},
		'{4'd3, 4'd4, 4'd5},
		'{4'd6, 4'd7, 4'd8},
		'{4'd0, 4'd3, 4'd6},
		'{4'd1, 4'd4, 4'd7},
		'{4'd2, 4'd5, 4'd8},
		'{4'd0, 4'd4, 4'd8},
		'{4'd2, 4'd4, 4'd6}
	};

	cell_t cells [`TTT_CELLS];
	cell_t nxt_winner;
	pos_t nxt_pos1;
	pos_t nxt_pos2;
	pos_t nxt_pos3;
	logic nxt_full;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int k = 0; k < `TTT_CELLS; k++)
				cells[k] <= cell_empty;
		end
		else if (clear)
		begin
			for (int k = 0; k < `TTT_CELLS; k++)
				cells[k] <= cell_empty;
		end
		else if (we && wr_addr < `TTT_CELLS)
			cells[wr_addr] <= data_in;
	end

	always_comb
	begin
		for (int k = 0; k < `TTT_CELLS; k++)
			board[2*k +: 2] = cells[k];
	end

	// Scanned from the last line down so the first matching line wins.
	always_comb
	begin
		nxt_winner = cell_none;
		nxt_pos1 = pos_t'(`TTT_NO_POS);
		nxt_pos2 = pos_t'(`TTT_NO_POS);
		nxt_pos3 = pos_t'(`TTT_NO_POS);
		for (int l = 7; l >= 0; l--)
		begin
			if ((cells[line_tab[l][0]] == cell_cross || cells[line_tab[l][0]] == cell_nought)
				&& cells[line_tab[l][0]] == cells[line_tab[l][1]]
				&& cells[line_tab[l][1]] == cells[line_tab[l][2]])
			begin
				nxt_winner = cells[line_tab[l][0]];
				nxt_pos1 = line_tab[l][0];
				nxt_pos2 = line_tab[l][1];
				nxt_pos3 = line_tab[l][2];
			end
		end
	end

	always_comb
	begin
		nxt_full = 1'b1;
		for (int k = 0; k < `TTT_CELLS; k++)
			if (cells[k] == cell_empty)
				nxt_full = 1'b0;
	end

	// Results lag the board by one clock.
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			winner <= cell_none;
			pos1 <= pos_t'(`TTT_NO_POS);
			pos2 <= pos_t'(`TTT_NO_POS);
			pos3 <= pos_t'(`TTT_NO_POS);
			win <= 1'b0;
			full <= 1'b0;
		end
		else
		begin
			winner <= nxt_winner;
			pos1 <= nxt_pos1;
			pos2 <= nxt_pos2;
			pos3 <= nxt_pos3;
			win <= nxt_winner == cell_cross || nxt_winner == cell_nought;
			full <= nxt_full;
		end
	end

endmodule

// File: source/move_controller.sv
`timescale 1ns/1ps
`include "ttt_config.svh"

module move_controller (
	input logic clk,
	input logic reset,
	input logic move_req,
	input logic new_game,
	input ttt_game_pkg::pos_t move_cell,
	input logic [2*`TTT_CELLS-1:0] board,
	input logic win,
	input logic full,
	output logic move_done,
	output logic move_ok,
	output logic we,
	output logic clear,
	output ttt_game_pkg::pos_t wr_addr,
	output ttt_game_pkg::cell_t data_in,
	output ttt_game_pkg::cell_t turn,
	output logic over
);

	import ttt_game_pkg::*;

	cell_t target;
	logic in_range;
	logic legal;

	// Current content of the requested cell.
	always_comb
	begin
		target = cell_none;
		for (int k = 0; k < `TTT_CELLS; k++)
			if (move_cell == pos_t'(k))
				target = cell_t'(board[2*k +: 2]);
	end

	assign in_range = move_cell < pos_t'(`TTT_CELLS);
	assign over = win || full;
	assign legal = in_range && target == cell_empty && !over;

	// Memory write happens on the decision edge.
	assign we = move_req && legal;
	assign wr_addr = move_cell;
	assign data_in = turn;
	assign clear = new_game;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			turn <= cell_cross;
		else if (new_game)
			turn <= cell_cross;
		else if (we)
			turn <= (turn == cell_cross) ? cell_nought : cell_cross;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			move_done <= 1'b0;
			move_ok <= 1'b0;
		end
		else
		begin
			move_done <= move_req;
			move_ok <= move_req && legal;
		end
	end

endmodule

// File: source/ttt_axil_slave.sv
`timescale 1ns/1ps
`include "ttt_config.svh"

module ttt_axil_slave (
	input logic clk,
	input logic reset,
	input logic [`TTT_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [`TTT_DATA_W-1:0] wdata,
	input logic [`TTT_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`TTT_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [`TTT_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic move_req,
	output logic new_game,
	output ttt_game_pkg::pos_t move_cell,
	input logic move_done,
	input logic move_ok,
	input logic [2*`TTT_CELLS-1:0] board,
	input ttt_game_pkg::cell_t winner,
	input ttt_game_pkg::cell_t turn,
	input logic win,
	input logic full,
	input logic over,
	input ttt_game_pkg::pos_t pos1,
	input ttt_game_pkg::pos_t pos2,
	input ttt_game_pkg::pos_t pos3
);

	import ttt_regs_pkg::*;
	import ttt_game_pkg::*;

	logic wr_busy;
	logic wr_accept;
	logic wr_move;
	logic wr_mapped;
	logic other_req;
	logic other_ack;
	logic [1:0] other_resp;
	logic [1:0] other_ack_resp;
	logic rd_accept;
	logic [`TTT_DATA_W-1:0] rd_value;
	logic [1:0] rd_resp;

	// AW and W are taken together, one write in flight.
	assign wr_accept = awvalid && wvalid && !wr_busy;
	assign awready = wr_accept;
	assign wready = wr_accept;

	assign wr_move = awaddr == reg_move && wstrb[0];
	assign wr_mapped = awaddr == reg_move || awaddr == reg_control
		|| awaddr == reg_status || awaddr == reg_board || awaddr == reg_line;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_busy <= 1'b0;
			move_req <= 1'b0;
			new_game <= 1'b0;
			other_req <= 1'b0;
			other_ack <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			move_req <= wr_accept && wr_move;
			new_game <= wr_accept && awaddr == reg_control && wstrb[0] && wdata[ctl_new_game];
			other_req <= wr_accept && !wr_move;
			// Non-move writes are delayed to answer on the same edge as a move.
			other_ack <= other_req;
			if (wr_accept)
				wr_busy <= 1'b1;
			else if (bvalid && bready)
				wr_busy <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			else if (move_done || other_ack)
				bvalid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_accept)
		begin
			move_cell <= pos_t'(wdata[3:0]);
			other_resp <= wr_mapped ? resp_okay : resp_slverr;
		end
		other_ack_resp <= other_resp;
		if (move_done)
			bresp <= move_ok ? resp_okay : resp_slverr;
		else if (other_ack)
			bresp <= other_ack_resp;
	end

	// Read data mux.
	always_comb
	begin
		rd_value = '0;
		rd_resp = resp_okay;
		case (araddr)
			reg_move, reg_control:
				rd_value = '0;
			reg_status:
			begin
				rd_value[st_winner +: 2] = winner;
				rd_value[st_win] = win;
				rd_value[st_full] = full;
				rd_value[st_turn +: 2] = turn;
				rd_value[st_over] = over;
			end
			reg_board:
				rd_value[2*`TTT_CELLS-1:0] = board;
			reg_line:
				rd_value[11:0] = {pos3, pos2, pos1};
			default:
				rd_resp = resp_slverr;
		endcase
	end

	assign arready = !rvalid;
	assign rd_accept = arvalid && arready;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rvalid <= 1'b0;
		else if (rvalid && rready)
			rvalid <= 1'b0;
		else if (rd_accept)
			rvalid <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rd_accept)
		begin
			rdata <= rd_value;
			rresp <= rd_resp;
		end
	end

endmodule

// File: source/tic_tac_toe_top.sv
`timescale 1ns/1ps
`include "ttt_config.svh"

module tic_tac_toe_top (
	input logic clk,
	input logic reset,
	input logic [`TTT_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [`TTT_DATA_W-1:0] wdata,
	input logic [`TTT_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`TTT_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [`TTT_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	import ttt_game_pkg::*;

	logic move_req;
	logic new_game;
	pos_t move_cell;
	logic move_done;
	logic move_ok;
	logic we;
	logic clear;
	pos_t wr_addr;
	cell_t data_in;
	cell_t turn;
	logic over;
	logic [2*`TTT_CELLS-1:0] board;
	cell_t winner;
	pos_t pos1;
	pos_t pos2;
	pos_t pos3;
	logic win;
	logic full;

	ttt_axil_slave u_slave (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.move_req(move_req), .new_game(new_game), .move_cell(move_cell),
		.move_done(move_done), .move_ok(move_ok),
		.board(board), .winner(winner), .turn(turn), .win(win), .full(full),
		.over(over), .pos1(pos1), .pos2(pos2), .pos3(pos3)
	);

	move_controller u_ctrl (
		.clk(clk), .reset(reset),
		.move_req(move_req), .new_game(new_game), .move_cell(move_cell),
		.board(board), .win(win), .full(full),
		.move_done(move_done), .move_ok(move_ok), .we(we), .clear(clear),
		.wr_addr(wr_addr), .data_in(data_in), .turn(turn), .over(over)
	);

	game_state_memory u_mem (
		.clk(clk), .reset(reset), .clear(clear), .we(we),
		.wr_addr(wr_addr), .data_in(data_in),
		.board(board), .winner(winner),
		.pos1(pos1), .pos2(pos2), .pos3(pos3),
		.win(win), .full(full)
	);

endmodule

// File: tests/tic_tac_toe_chk.sv
`timescale 1ns/1ps

module tic_tac_toe_chk (
	input logic clk,
	input logic reset,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic rvalid,
	input logic rready,
	input logic win,
	input ttt_game_pkg::cell_t winner
);

	import ttt_game_pkg::*;

	// A response stays up until the master takes it.
	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready was seen");

	a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready was seen");

	a_bresp_stable: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> $stable(bresp))
		else $error("bresp changed while the write response was waiting");

	// A win always names its player.
	a_win_winner: assert property (@(posedge clk) disable iff (reset)
		win |-> winner != cell_none)
		else $error("win is set while winner reads none");

endmodule

bind ttt_axil_slave tic_tac_toe_chk u_chk (
	.clk(clk), .reset(reset),
	.bvalid(bvalid), .bready(bready), .bresp(bresp),
	.rvalid(rvalid), .rready(rready),
	.win(win), .winner(winner)
);

// File: tests/tic_tac_toe_tb.sv
`timescale 1ns/1ps
`include "ttt_config.svh"

module tic_tac_toe_tb;

	import ttt_regs_pkg::*;

	logic clk;
	logic reset;
	logic [`TTT_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`TTT_DATA_W-1:0] wdata;
	logic [`TTT_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`TTT_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`TTT_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// Handshakes captured at the last rising edge.
	logic aw_seen;
	logic b_seen;
	logic ar_seen;
	logic r_seen;
	logic [1:0] b_resp_q;
	logic [1:0] r_resp_q;
	logic [`TTT_DATA_W-1:0] r_data_q;

	integer seed;
	integer stim_lines;
	integer test_errors;
	integer pass_count;
	integer fail_count;

	tic_tac_toe_top u_dut (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		if (reset)
		begin
			aw_seen <= 1'b0;
			b_seen <= 1'b0;
			ar_seen <= 1'b0;
			r_seen <= 1'b0;
		end
		else
		begin
			aw_seen <= awvalid && awready && wvalid && wready;
			b_seen <= bvalid && bready;
			ar_seen <= arvalid && arready;
			r_seen <= rvalid && rready;
			if (bvalid && bready)
				b_resp_q <= bresp;
			if (rvalid && rready)
			begin
				r_data_q <= rdata;
				r_resp_q <= rresp;
			end
		end
	end

	// Only the five register offsets are mapped.
	function automatic logic [1:0] expected_rresp(input logic [`TTT_ADDR_W-1:0] addr);
		if (addr == 5'h00 || addr == 5'h04 || addr == 5'h08 || addr == 5'h0c || addr == 5'h10)
			return resp_okay;
		return resp_slverr;
	endfunction

	// Channel 0 is AW and W, 1 is B, 2 is AR, 3 is R.
	task automatic wait_handshake(input int channel, output logic seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < 16)
		begin
			@(negedge clk);
			cycles++;
			case (channel)
				0: seen = aw_seen;
				1: seen = b_seen;
				2: seen = ar_seen;
				default: seen = r_seen;
			endcase
		end
	endtask

	task automatic ready_delay;
		int d;
		d = $random(seed) & 3;
		repeat (d) @(negedge clk);
	endtask

	task automatic axil_write(input logic [`TTT_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp, output logic done);
		logic seen;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = '1;
		awvalid = 1'b1;
		wvalid = 1'b1;
		wait_handshake(0, seen);
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!seen)
			$display("write to 0x%h was never accepted on AW and W", addr);
		else
		begin
			ready_delay();
			bready = 1'b1;
			wait_handshake(1, seen);
			bready = 1'b0;
			if (!seen)
				$display("write to 0x%h got no write response", addr);
		end
		resp = b_resp_q;
		done = seen;
	endtask

	task automatic axil_read(input logic [`TTT_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp, output logic done);
		logic seen;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		wait_handshake(2, seen);
		arvalid = 1'b0;
		if (!seen)
			$display("read of 0x%h was never accepted on AR", addr);
		else
		begin
			ready_delay();
			rready = 1'b1;
			wait_handshake(3, seen);
			rready = 1'b0;
			if (!seen)
				$display("read of 0x%h returned no data", addr);
		end
		data = r_data_q;
		resp = r_resp_q;
		done = seen;
	endtask

	task automatic close_test(input logic [8*24-1:0] name);
		if (test_errors == 0)
		begin
			pass_count++;
			$display("test %0s passed", name);
		end
		else
		begin
			fail_count++;
			$display("test %0s failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic run_stim(input integer fd);
		logic [7:0] kind;
		logic [8*24-1:0] name;
		logic [8*128-1:0] text;
		logic [`TTT_ADDR_W-1:0] addr;
		logic [31:0] data;
		logic [31:0] expected;
		logic [1:0] resp;
		logic [1:0] exp_resp;
		logic done;
		integer code;
		code = $fscanf(fd, "%s", kind);
		while (code == 1)
		begin
			if (kind == "#")
				code = $fgets(text, fd);
			else if (kind == "w")
			begin
				code = $fscanf(fd, "%h %h %h", addr, data, exp_resp);
				axil_write(addr, data, resp, done);
				if (!done)
					test_errors++;
				else if (resp !== exp_resp)
				begin
					$display("error: bresp for 0x%h expected 0x%h actual 0x%h",
						addr, exp_resp, resp);
					test_errors++;
				end
			end
			else if (kind == "r")
			begin
				code = $fscanf(fd, "%h %h", addr, expected);
				axil_read(addr, data, resp, done);
				exp_resp = expected_rresp(addr);
				if (!done)
					test_errors++;
				else if (resp !== exp_resp)
				begin
					$display("error: rresp for 0x%h expected 0x%h actual 0x%h",
						addr, exp_resp, resp);
					test_errors++;
				end
				else if (exp_resp == resp_okay && data !== expected)
				begin
					$display("error: rdata for 0x%h expected 0x%h actual 0x%h",
						addr, expected, data);
					test_errors++;
				end
			end
			else if (kind == "t")
			begin
				code = $fscanf(fd, "%s", name);
				close_test(name);
			end
			else
			begin
				$display("stim file holds a line of unknown kind %0s", kind);
				test_errors++;
			end
			code = $fscanf(fd, "%s", kind);
		end
	endtask

	initial
	begin
		integer fd;
		logic [8*128-1:0] line;
		clk = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		seed = 32'hede1;
		stim_lines = 0;
		test_errors = 0;
		pass_count = 0;
		fail_count = 0;
		fd = $fopen("tests/tic_tac_toe_stim.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stim file tests/tic_tac_toe_stim.txt");
			fail_count = 1;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
				stim_lines++;
			$fclose(fd);
			repeat (8) @(posedge clk);
			@(negedge clk);
			reset = 1'b0;
			fd = $fopen("tests/tic_tac_toe_stim.txt", "r");
			run_stim(fd);
			$fclose(fd);
		end
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && test_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Twenty clocks per stim line.
	initial
	begin
		@(negedge reset);
		#(stim_lines * 20 * 100);
		$display("watchdog expired before the stim sequence finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: build.f
+incdir+source
source/ttt_game_pkg.sv
source/ttt_regs_pkg.sv
source/game_state_memory.sv
source/move_controller.sv
source/ttt_axil_slave.sv
source/tic_tac_toe_top.sv
tests/tic_tac_toe_chk.sv
tests/tic_tac_toe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the tic-tac-toe testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tic_tac_toe_tb \
	-f build.f \
	-o tic_tac_toe_sim

./obj_dir/tic_tac_toe_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished without failures"

// File: tests/tic_tac_toe_stim.txt
# w addr data bresp | r addr rdata | t test_name
# Numbers are hex, bresp 0 is okay and 2 is slverr.
r 08 00000013
r 0c 00000000
r 10 00000fff
r 00 00000000
t reset_state
w 00 00000004 0
w 00 00000000 0
w 00 00000008 0
r 0c 00010102
r 08 00000023
t legal_moves
w 00 00000004 2
w 00 00000009 2
r 0c 00010102
r 08 00000023
t illegal_moves
w 00 00000001 0
w 00 00000003 0
w 00 00000002 0
r 08 00000056
r 10 00000210
w 00 00000005 2
r 0c 0001016a
t row_win
w 04 00000001 0
w 00 00000000 0
w 00 00000001 0
w 00 00000002 0
w 00 00000004 0
w 00 00000003 0
w 00 00000005 0
w 00 00000007 0
w 00 00000006 0
w 00 00000008 0
r 08 0000006b
r 0c 00016a59
r 10 00000fff
w 00 00000004 2
t full_board
w 04 00000001 0
r 08 00000013
r 0c 00000000
w 00 00000004 0
r 0c 00000100
w 14 00000000 2
r 14 00000000
r 08 00000023
t restart
